/* hdl/rvCorePkg.sv */
`default_nettype none

package rvCorePkg;

    typedef enum logic [4:0] {
        LOAD   = 5'b00000, // Loads, not executed here
        STORE  = 5'b01000,
        OP_IMM = 5'b00100, // Register-immediate ALU ops
        OP     = 5'b01100, // Register-register ALU ops
        LUI    = 5'b01101,
        AUIPC  = 5'b00101,
        BRANCH = 5'b11000,
        JAL    = 5'b11011,
        JALR   = 5'b11001,
        SYSTEM = 5'b11100
    } OpCode;

    typedef logic [4:0]  RegAddr;
    typedef logic [31:0] Word;

    localparam int NumRegs = 32; // x0 included

    typedef enum logic [3:0] {
        ADD   = 4'd0,
        SUB   = 4'd1,
        COMP  = 4'd2, // Set-less-than, result 0 or 1
        XOR   = 4'd3,
        OR    = 4'd4,
        AND   = 4'd5,
        LSHFT = 4'd6,
        RSHFT = 4'd7,
        PASSB = 4'd8  // Operand B straight through
    } AluCtrl;

    typedef struct packed {
        AluCtrl ctrl;
        logic   isUnsignedCompOrLeftShift; // funct3[0]
        logic   isArith;                   // funct7[5], SRA over SRL
    } DecodedAluCmd;

    typedef struct packed {
        logic [6:0] funct7;
        RegAddr     rs2;
        RegAddr     rs1;
        logic [2:0] funct3;
        RegAddr     rd;
        OpCode      opCode;
        logic [1:0] lowBits; // 2'b11 for every 32-bit encoding
    } RTypeInstr;

    typedef struct packed {
        logic [19:0] imm20;
        RegAddr      rd;
        OpCode       opCode;
        logic [1:0]  lowBits;
    } UTypeInstr;

    // Same word, two field layouts
    typedef union packed {
        RTypeInstr rType;
        UTypeInstr uType;
    } Instruction;

    typedef struct packed {
        Instruction instr;
        Word        pc;
    } IssueReq;

    typedef struct packed {
        logic         valid;
        RegAddr       rd;
        DecodedAluCmd aluCmd;
        Word          opA;
        Word          opB;
        logic         illegal;
    } IssueStage;

    typedef struct packed {
        logic   valid;
        RegAddr rd;
        Word    value;
        logic   illegal; // Reported only, never committed
    } ExecResult;

endpackage

`default_nettype wire

/* hdl/instrStencil.sv */
`timescale 1ns/1ps
`default_nettype none

module instrStencil (
    input  rvCorePkg::Instruction   instr,
    output rvCorePkg::OpCode        opCode,
    output rvCorePkg::DecodedAluCmd decodedAluCmd,
    output rvCorePkg::Word          imm,
    output logic                    useImm,
    output logic                    illegal
);
    import rvCorePkg::*;

    localparam logic [2:0] Funct3Add  = 3'b000;
    localparam logic [2:0] Funct3Sll  = 3'b001;
    localparam logic [2:0] Funct3Slt  = 3'b010;
    localparam logic [2:0] Funct3Sltu = 3'b011;
    localparam logic [2:0] Funct3Xor  = 3'b100;
    localparam logic [2:0] Funct3Srla = 3'b101;
    localparam logic [2:0] Funct3Or   = 3'b110;
    localparam logic [2:0] Funct3And  = 3'b111;

    logic legalOp;

    assign opCode = instr.rType.opCode;

    assign decodedAluCmd.isUnsignedCompOrLeftShift = instr.rType.funct3[0];
    assign decodedAluCmd.isArith                   = instr.rType.funct7[5];

    always_comb begin
        decodedAluCmd.ctrl = ADD; // AUIPC and anything illegal
        case (opCode)
            OP, OP_IMM: begin
                case (instr.rType.funct3)
                    Funct3Add:  decodedAluCmd.ctrl =
                        (opCode == OP && instr.rType.funct7[5]) ? SUB : ADD;
                    Funct3Sll:  decodedAluCmd.ctrl = LSHFT;
                    Funct3Slt:  decodedAluCmd.ctrl = COMP;
                    Funct3Sltu: decodedAluCmd.ctrl = COMP;
                    Funct3Xor:  decodedAluCmd.ctrl = XOR;
                    Funct3Srla: decodedAluCmd.ctrl = RSHFT; // isArith picks SRA
                    Funct3Or:   decodedAluCmd.ctrl = OR;
                    Funct3And:  decodedAluCmd.ctrl = AND;
                endcase
            end
            LUI:     decodedAluCmd.ctrl = PASSB;
            default: decodedAluCmd.ctrl = ADD;
        endcase
    end

    always_comb begin
        if (opCode == LUI || opCode == AUIPC) begin
            imm = {instr.uType.imm20, 12'b0}; // U-immediate
        end else begin
            // I-immediate, shamt sits in the low five bits
            imm = {{20{instr.rType.funct7[6]}}, instr.rType.funct7, instr.rType.rs2};
        end
    end

    assign useImm  = (opCode inside {OP_IMM, LUI, AUIPC});
    assign legalOp = (opCode inside {OP, OP_IMM, LUI, AUIPC});
    assign illegal = !legalOp || (instr.rType.lowBits != 2'b11);

endmodule

`default_nettype wire

/* hdl/instrIssue.sv */
`timescale 1ns/1ps
`default_nettype none

module instrIssue (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issueValid,
    input  rvCorePkg::IssueReq   issue,
    input  rvCorePkg::ExecResult aluNext,
    input  rvCorePkg::ExecResult result,
    output rvCorePkg::RegAddr    rs1,
    output rvCorePkg::RegAddr    rs2,
    input  rvCorePkg::Word       rdData1,
    input  rvCorePkg::Word       rdData2,
    output rvCorePkg::IssueStage stage
);
    import rvCorePkg::*;

    OpCode        opCode;
    DecodedAluCmd aluCmd;
    Word          imm;
    logic         useImm;
    logic         illegal;
    Word          src1;
    Word          src2;
    IssueStage    nextStage;

    // Youngest in-flight writer wins, register file last
    function automatic Word forward(input RegAddr addr, input Word regData,
                                    input ExecResult young, input ExecResult old);
        Word value;
        value = regData;
        if (addr != '0 && old.valid && !old.illegal && old.rd == addr) begin
            value = old.value;
        end
        if (addr != '0 && young.valid && !young.illegal && young.rd == addr) begin
            value = young.value;
        end
        return value;
    endfunction

    instrStencil stencil_i (
        .instr         (issue.instr),
        .opCode        (opCode),
        .decodedAluCmd (aluCmd),
        .imm           (imm),
        .useImm        (useImm),
        .illegal       (illegal)
    );

    assign rs1 = issue.instr.rType.rs1;
    assign rs2 = issue.instr.rType.rs2;

    assign src1 = forward(rs1, rdData1, aluNext, result);
    assign src2 = forward(rs2, rdData2, aluNext, result);

    always_comb begin
        nextStage.valid   = issueValid;
        nextStage.rd      = issue.instr.rType.rd;
        nextStage.aluCmd  = aluCmd;
        nextStage.illegal = illegal;
        case (opCode)
            AUIPC:   nextStage.opA = issue.pc;
            LUI:     nextStage.opA = '0; // Ignored by PASSB
            default: nextStage.opA = src1;
        endcase
        nextStage.opB = useImm ? imm : src2;
    end

    always_ff @(posedge clk) begin
        stage <= nextStage;
        if (rst) begin
            stage.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hdl/intAlu.sv */
`timescale 1ns/1ps
`default_nettype none

module intAlu (
    input  logic                 clk,
    input  logic                 rst,
    input  rvCorePkg::IssueStage stage,
    output rvCorePkg::ExecResult aluNext,
    output rvCorePkg::ExecResult result
);
    import rvCorePkg::*;

    Word        opA;
    Word        opB;
    logic [4:0] shamt;
    logic       lessThan;
    Word        aluOut;

    assign opA   = stage.opA;
    assign opB   = stage.opB;
    assign shamt = opB[4:0];

    always_comb begin
        if (stage.aluCmd.isUnsignedCompOrLeftShift) begin
            lessThan = (opA < opB); // SLTU
        end else begin
            lessThan = ($signed(opA) < $signed(opB));
        end
    end

    always_comb begin
        case (stage.aluCmd.ctrl)
            ADD:   aluOut = opA + opB;
            SUB:   aluOut = opA - opB;
            COMP:  aluOut = {31'b0, lessThan};
            XOR:   aluOut = opA ^ opB;
            OR:    aluOut = opA | opB;
            AND:   aluOut = opA & opB;
            LSHFT: aluOut = opA << shamt;
            RSHFT: begin
                if (stage.aluCmd.isArith) begin
                    aluOut = Word'($signed(opA) >>> shamt);
                end else begin
                    aluOut = opA >> shamt;
                end
            end
            PASSB:   aluOut = opB;
            default: aluOut = '0; // Unused encodings
        endcase
    end

    assign aluNext.valid   = stage.valid;
    assign aluNext.rd      = stage.rd;
    assign aluNext.value   = aluOut;
    assign aluNext.illegal = stage.illegal;

    always_ff @(posedge clk) begin
        result <= aluNext;
        if (rst) begin
            result.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* hdl/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic                 clk,
    input  logic                 rst,
    input  rvCorePkg::RegAddr    rs1,
    input  rvCorePkg::RegAddr    rs2,
    output rvCorePkg::Word       rdData1,
    output rvCorePkg::Word       rdData2,
    input  rvCorePkg::ExecResult result
);
    import rvCorePkg::*;

    Word  regs [1:NumRegs-1]; // x0 has no storage
    logic commit;

    assign commit = result.valid && !result.illegal && (result.rd != '0);

    // Write-first, a commit in this cycle is seen at once
    function automatic Word readPort(input RegAddr addr);
        if (addr == '0) begin
            return '0;
        end
        if (commit && result.rd == addr) begin
            return result.value;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdData1 = readPort(rs1);
        rdData2 = readPort(rs2);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (commit) begin
            regs[result.rd] <= result.value;
        end
    end

endmodule

`default_nettype wire

/* hdl/rvExecUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module rvExecUnit (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issueValid,
    input  rvCorePkg::IssueReq   issue,
    output rvCorePkg::ExecResult result
);
    import rvCorePkg::*;

    IssueStage stage;
    ExecResult aluNext;
    RegAddr    rs1;
    RegAddr    rs2;
    Word       rdData1;
    Word       rdData2;

    instrIssue issue_i (
        .clk        (clk),
        .rst        (rst),
        .issueValid (issueValid),
        .issue      (issue),
        .aluNext    (aluNext),  // One stage older, combinational
        .result     (result),
        .rs1        (rs1),
        .rs2        (rs2),
        .rdData1    (rdData1),
        .rdData2    (rdData2),
        .stage      (stage)
    );

    intAlu alu_i (
        .clk     (clk),
        .rst     (rst),
        .stage   (stage),
        .aluNext (aluNext),
        .result  (result)
    );

    regFile regs_i (
        .clk     (clk),
        .rst     (rst),
        .rs1     (rs1),
        .rs2     (rs2),
        .rdData1 (rdData1),
        .rdData2 (rdData2),
        .result  (result)
    );

endmodule

`default_nettype wire

/* dv/clkGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clkGen (
    output logic clk,
    output logic rst
);
    localparam int HalfPeriod  = 4; // 8 ns clock
    localparam int ResetCycles = 4;

    initial begin
        clk = 1'b0;
        forever #HalfPeriod clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        rst <= 1'b0; // Released just after the 4th edge
    end

endmodule

`default_nettype wire

/* dv/resultChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module resultChecker (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issueValid,
    input  rvCorePkg::IssueReq   issue,
    input  rvCorePkg::ExecResult result,
    output int                   checkCount,
    output int                   errorCount,
    output int                   pendingCount
);
    import rvCorePkg::*;

    typedef struct packed {
        ExecResult   exp;
        logic [31:0] cycle; // Cycle of the strobe
    } Expected;

    Word         shadow [NumRegs]; // x0 is never written
    Expected     pending [$];
    logic [31:0] cycleCnt = '0;
    int          checks = 0;
    int          errors = 0;
    int          outstanding = 0;

    assign checkCount   = checks;
    assign errorCount   = errors;
    assign pendingCount = outstanding;

    function automatic Word aluRef(input logic [2:0] funct3, input logic sub,
                                   input logic arith, input Word a, input Word b);
        case (funct3)
            3'b000:  return sub ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, $signed(a) < $signed(b)};
            3'b011:  return {31'b0, a < b};
            3'b100:  return a ^ b;
            3'b101:  return arith ? Word'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic ExecResult expectedResult(input Word word, input Word pc);
        ExecResult exp;
        Word       immI;
        Word       immU;
        immI        = {{20{word[31]}}, word[31:20]};
        immU        = {word[31:12], 12'h000};
        exp.valid   = 1'b1;
        exp.rd      = word[11:7];
        exp.value   = '0;
        exp.illegal = 1'b0;
        if (word[1:0] != 2'b11) begin
            exp.illegal = 1'b1;
        end else begin
            case (word[6:2])
                5'b01100: exp.value = aluRef(word[14:12], word[30], word[30], // OP
                                             shadow[word[19:15]], shadow[word[24:20]]);
                5'b00100: exp.value = aluRef(word[14:12], 1'b0, word[30], // OP_IMM
                                             shadow[word[19:15]], immI);
                5'b01101: exp.value = immU;      // LUI
                5'b00101: exp.value = pc + immU; // AUIPC
                default:  exp.illegal = 1'b1;
            endcase
        end
        return exp;
    endfunction

    // Strobes are stable at the rising edge
    always @(posedge clk) begin : capture
        Expected entry;
        cycleCnt <= cycleCnt + 1;
        if (rst) begin
            for (int i = 0; i < NumRegs; i++) begin
                shadow[i] = '0;
            end
            pending.delete();
        end else if (issueValid) begin
            entry.exp   = expectedResult(issue.instr, issue.pc);
            entry.cycle = cycleCnt;
            if (!entry.exp.illegal && entry.exp.rd != '0) begin
                shadow[entry.exp.rd] = entry.exp.value;
            end
            pending.push_back(entry);
        end
    end

    // Results are stable at the falling edge
    always @(negedge clk) begin : compare
        Expected head;
        if (rst) begin
            // Nothing is clocked yet before the first rising edge
            if (cycleCnt != 0 && result.valid !== 1'b0) begin
                $display("result.valid was not low during reset at time %0t", $time);
                errors++;
            end
        end else begin
            if (result.valid === 1'b1) begin
                if (pending.size() == 0) begin
                    $display("A result arrived at time %0t with no instruction outstanding",
                             $time);
                    errors++;
                end else begin
                    head = pending.pop_front();
                    checks++;
                    if (cycleCnt != head.cycle + 2) begin
                        $display("ERROR %0t: result came %0d cycles after its strobe, not 2",
                                 $time, cycleCnt - head.cycle);
                        errors++;
                    end
                    if (result.rd !== head.exp.rd || result.illegal !== head.exp.illegal
                            || (!head.exp.illegal && result.value !== head.exp.value)) begin
                        $display("ERROR %0t: got x%0d=%h illegal %b, expected x%0d=%h illegal %b",
                                 $time, result.rd, result.value, result.illegal,
                                 head.exp.rd, head.exp.value, head.exp.illegal);
                        errors++;
                    end
                end
            end
            while (pending.size() != 0 && cycleCnt >= pending[0].cycle + 2) begin
                $display("The result of the instruction strobed in cycle %0d did not arrive",
                         pending[0].cycle);
                void'(pending.pop_front());
                errors++;
            end
        end
        outstanding = pending.size();
    end

endmodule

`default_nettype wire

/* dv/tbTop.sv */
`timescale 1ns/1ps
`default_nettype none

module tbTop;
    import rvCorePkg::*;

    localparam int NumInstr     = 400;
    localparam int ResetTimeout = 20;   // Cycles
    localparam int StimTimeout  = 4000;
    localparam int DrainTimeout = 20;

    logic        clk;
    logic        rst;
    logic        issueValid;
    IssueReq     issue;
    ExecResult   result;
    int          checkCount;
    int          errorCount;
    int          pendingCount;
    logic [31:0] lfsr = 32'h90ae_b869;
    Word         pc;
    int          sent;
    int          waited;
    bit          timedOut;

    clkGen clkGen_i (
        .clk (clk),
        .rst (rst)
    );

    rvExecUnit dut_i (
        .clk        (clk),
        .rst        (rst),
        .issueValid (issueValid),
        .issue      (issue),
        .result     (result)
    );

    resultChecker checker_i (
        .clk          (clk),
        .rst          (rst),
        .issueValid   (issueValid),
        .issue        (issue),
        .result       (result),
        .checkCount   (checkCount),
        .errorCount   (errorCount),
        .pendingCount (pendingCount)
    );

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] nextLfsr(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [31:0] takeBits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = nextLfsr(lfsr);
            bits = {bits[30:0], lfsr[0]};
        end
        return bits;
    endfunction

    // Mostly x0..x7 so that neighbours depend on each other
    function automatic RegAddr pickReg();
        if (takeBits(3) != 0) begin
            return RegAddr'(takeBits(3));
        end
        return RegAddr'(takeBits(5));
    endfunction

    function automatic logic [31:0] makeInstr();
        logic [2:0]  kind;
        logic [4:0]  opc;
        logic [1:0]  low;
        logic [31:0] word;
        kind        = 3'(takeBits(3));
        low         = 2'b11;
        word        = '0;
        word[11:7]  = pickReg();
        word[19:15] = pickReg();
        word[14:12] = 3'(takeBits(3));
        case (kind)
            3'd0, 3'd1, 3'd2: begin
                opc         = OP;
                word[24:20] = pickReg();
                word[30]    = 1'(takeBits(1)); // SUB and SRA
            end
            3'd3, 3'd4: begin
                opc         = OP_IMM;
                word[31:20] = 12'(takeBits(12)); // Half of them negative
            end
            3'd5: begin
                opc         = LUI;
                word[31:12] = 20'(takeBits(20));
            end
            3'd6: begin
                opc         = AUIPC;
                word[31:12] = 20'(takeBits(20));
            end
            default: begin
                word[31:20] = 12'(takeBits(12));
                if (1'(takeBits(1))) begin
                    opc = OP;
                    low = 2'(takeBits(2));
                    if (low == 2'b11) begin
                        low = 2'b10; // Never a valid 32-bit encoding
                    end
                end else begin
                    case (2'(takeBits(2)))
                        2'd0:    opc = LOAD;
                        2'd1:    opc = STORE;
                        2'd2:    opc = BRANCH;
                        default: opc = JAL;
                    endcase
                end
            end
        endcase
        word[6:0] = {opc, low};
        return word;
    endfunction

    initial begin
        issueValid  = 1'b1; // Strobe held through reset, must be dropped
        issue.instr = 32'h0050_0093; // ADDI x1, x0, 5
        issue.pc    = '0;
        pc          = 32'h0000_1000;
        sent        = 0;
        timedOut    = 1'b0;

        waited = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (rst && waited < ResetTimeout);
        if (rst) begin
            $display("Reset was still asserted after %0d cycles", ResetTimeout);
            timedOut = 1'b1;
        end

        waited = 0;
        while (!timedOut && sent < NumInstr && waited < StimTimeout) begin
            if (takeBits(2) != 0) begin
                issueValid  = 1'b1;
                issue.instr = makeInstr();
                issue.pc    = pc;
                pc          = pc + 4;
                sent++;
            end else begin
                issueValid = 1'b0;
            end
            @(negedge clk);
            waited++;
        end
        issueValid = 1'b0;
        if (!timedOut && sent < NumInstr) begin
            $display("Only %0d of %0d instructions were sent in time", sent, NumInstr);
            timedOut = 1'b1;
        end

        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (pendingCount != 0 && waited < DrainTimeout);
        if (pendingCount != 0) begin
            $display("Timed out waiting for %0d outstanding results", pendingCount);
            timedOut = 1'b1;
        end
        repeat (4) @(posedge clk); // Catch any stray result

        if (checkCount != sent) begin
            $display("Checked %0d results for %0d instructions", checkCount, sent);
            timedOut = 1'b1;
        end
        $display("instructions %0d, checks %0d, errors %0d", sent, checkCount, errorCount);
        if (errorCount == 0 && !timedOut) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
hdl/rvCorePkg.sv
hdl/instrStencil.sv
hdl/instrIssue.sv
hdl/intAlu.sv
hdl/regFile.sv
hdl/rvExecUnit.sv
dv/clkGen.sv
dv/resultChecker.sv
dv/tbTop.sv

/* Makefile */
SIM   ?= verilator
TOP   ?= tbTop
LOG   ?= sim.log
BUILD ?= obj_dir
FLIST ?= all.f

SOURCES := $(shell grep -v '^+' $(FLIST))
BIN     := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BUILD)/V%: $(FLIST) $(SOURCES)
	$(SIM) --binary -f $(FLIST) --top-module $* -Mdir $(BUILD)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q '^sim passed$$' $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
